/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_count  = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    localparam word_t     reset_pc  = 32'h0000_0000;
    localparam word_t     exit_addr = 32'h0000_0400; // fetch here raises exit
    localparam reg_addr_t gp_reg    = 5'd3;

    // major opcodes, rv32i encoding
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_copy2 // op2 straight through
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu
    } br_op_e;

    typedef enum logic [1:0] {op1_rs1, op1_pc, op1_zero} op1_sel_e;
    typedef enum logic [1:0] {op2_rs2, op2_imm} op2_sel_e;
    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e;

    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_load  // waiting on data memory
    } core_state_e;

endpackage

`default_nettype wire

/* source/core_ctrl_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface core_ctrl_if;
    import core_pkg::*;

    alu_op_e   alu_op;
    br_op_e    br_op;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    wb_sel_e   wb_sel;
    logic      rf_wen;
    logic      mem_wen;
    logic      jump;     // jal or jalr
    logic      is_load;
    word_t     imm;      // immediate picked by the decoder
    word_t     br_imm;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;

    modport dec (output alu_op, br_op, op1_sel, op2_sel, wb_sel, rf_wen, mem_wen,
                 jump, is_load, imm, br_imm, rs1_addr, rs2_addr, rd_addr);
    modport alu (input alu_op, br_op);
    modport ctl (input op1_sel, op2_sel, wb_sel, rf_wen, mem_wen, jump, is_load,
                 imm, br_imm, rs1_addr, rs2_addr, rd_addr);

endinterface

`default_nettype wire

/* source/core_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module core_decoder (
    input  core_pkg::word_t instr_i,
    core_ctrl_if.dec        ctrl
);
    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    alu_op_e    funct_alu;
    logic       op_ok;
    logic       imm_ok;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign ctrl.rd_addr  = instr_i[11:7];
    assign ctrl.rs1_addr = instr_i[19:15];
    assign ctrl.rs2_addr = instr_i[24:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};

    assign ctrl.br_imm = imm_b;

    // legal funct7 patterns, sub and sra take the alternate bit
    assign op_ok  = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign imm_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                    (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                    1'b1;

    always_comb begin
        case (funct3)
            3'b000:  funct_alu = alu_add;
            3'b001:  funct_alu = alu_sll;
            3'b010:  funct_alu = alu_slt;
            3'b011:  funct_alu = alu_sltu;
            3'b100:  funct_alu = alu_xor;
            3'b101:  funct_alu = funct7[5] ? alu_sra : alu_srl;
            3'b110:  funct_alu = alu_or;
            default: funct_alu = alu_and;
        endcase
    end

    always_comb begin
        ctrl.alu_op  = alu_add;
        ctrl.br_op   = br_none;
        ctrl.op1_sel = op1_rs1;
        ctrl.op2_sel = op2_imm;
        ctrl.wb_sel  = wb_alu;
        ctrl.rf_wen  = 1'b0;
        ctrl.mem_wen = 1'b0;
        ctrl.jump    = 1'b0;
        ctrl.is_load = 1'b0;
        ctrl.imm     = imm_i;
        case (opcode)
            opc_op: if (op_ok) begin
                ctrl.alu_op  = (funct3 == 3'b000 && funct7[5]) ? alu_sub : funct_alu;
                ctrl.op2_sel = op2_rs2;
                ctrl.rf_wen  = 1'b1;
            end
            opc_op_imm: if (imm_ok) begin
                ctrl.alu_op = funct_alu;
                ctrl.rf_wen = 1'b1;
            end
            opc_load: if (funct3 == 3'b010) begin // lw only
                ctrl.wb_sel  = wb_mem;
                ctrl.rf_wen  = 1'b1;
                ctrl.is_load = 1'b1;
            end
            opc_store: if (funct3 == 3'b010) begin
                ctrl.imm     = imm_s;
                ctrl.mem_wen = 1'b1;
            end
            opc_branch: begin
                ctrl.op2_sel = op2_rs2;
                case (funct3)
                    3'b000:  ctrl.br_op = br_beq;
                    3'b001:  ctrl.br_op = br_bne;
                    3'b100:  ctrl.br_op = br_blt;
                    3'b101:  ctrl.br_op = br_bge;
                    3'b110:  ctrl.br_op = br_bltu;
                    3'b111:  ctrl.br_op = br_bgeu;
                    default: ctrl.br_op = br_none;
                endcase
            end
            opc_jal: begin
                ctrl.op1_sel = op1_pc;
                ctrl.imm     = imm_j;
                ctrl.wb_sel  = wb_pc4;
                ctrl.rf_wen  = 1'b1;
                ctrl.jump    = 1'b1;
            end
            opc_jalr: if (funct3 == 3'b000) begin
                ctrl.wb_sel = wb_pc4;
                ctrl.rf_wen = 1'b1;
                ctrl.jump   = 1'b1;
            end
            opc_lui: begin
                ctrl.op1_sel = op1_zero;
                ctrl.alu_op  = alu_copy2;
                ctrl.imm     = imm_u;
                ctrl.rf_wen  = 1'b1;
            end
            opc_auipc: begin
                ctrl.op1_sel = op1_pc;
                ctrl.imm     = imm_u;
                ctrl.rf_wen  = 1'b1;
            end
            default: ; // unknown, retires as nop
        endcase
    end

endmodule

`default_nettype wire

/* source/core_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module core_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    input  core_pkg::reg_addr_t rd_addr_i,
    input  logic                rd_wen_i,
    input  core_pkg::word_t     rd_data_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o,
    output core_pkg::word_t     gp_o
);
    import core_pkg::*;

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen_i && rd_addr_i != '0) begin // x0 stays zero
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
    assign gp_o       = regs[gp_reg];

endmodule

`default_nettype wire

/* source/core_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module core_alu (
    core_ctrl_if.alu        ctrl,
    input  core_pkg::word_t op1_i,
    input  core_pkg::word_t op2_i,
    output core_pkg::word_t result_o,
    output logic            br_taken_o
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = op2_i[4:0];
    assign lt_s  = $signed(op1_i) < $signed(op2_i);
    assign lt_u  = op1_i < op2_i;
    assign eq    = op1_i == op2_i;

    always_comb begin
        case (ctrl.alu_op)
            alu_add:   result_o = op1_i + op2_i;
            alu_sub:   result_o = op1_i - op2_i;
            alu_and:   result_o = op1_i & op2_i;
            alu_or:    result_o = op1_i | op2_i;
            alu_xor:   result_o = op1_i ^ op2_i;
            alu_sll:   result_o = op1_i << shamt;
            alu_srl:   result_o = op1_i >> shamt;
            alu_sra:   result_o = word_t'($signed(op1_i) >>> shamt);
            alu_slt:   result_o = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu:  result_o = {{(xlen-1){1'b0}}, lt_u};
            alu_copy2: result_o = op2_i; // lui
            default:   result_o = '0;
        endcase
    end

    // branch compare on rs1 vs rs2
    always_comb begin
        case (ctrl.br_op)
            br_beq:  br_taken_o = eq;
            br_bne:  br_taken_o = !eq;
            br_blt:  br_taken_o = lt_s;
            br_bge:  br_taken_o = !lt_s;
            br_bltu: br_taken_o = lt_u;
            br_bgeu: br_taken_o = !lt_u;
            default: br_taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/core.sv */
`timescale 1ns/1ns
`default_nettype none

module core (
    input  logic            clk,
    input  logic            rst_n,
    output core_pkg::word_t imem_addr_o,
    input  core_pkg::word_t imem_rdata_i,
    output core_pkg::word_t dmem_addr_o,
    output core_pkg::word_t dmem_wdata_o,
    output logic            dmem_wen_o,
    input  core_pkg::word_t dmem_rdata_i,
    output logic            exit_o,
    output core_pkg::word_t gp_o
);
    import core_pkg::*;

    core_state_e state_q;
    word_t       pc_q;
    word_t       pc_plus4;
    word_t       pc_next;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       op1;
    word_t       op2;
    word_t       alu_result;
    word_t       wb_data;
    logic        br_taken;
    logic        retire;

    core_ctrl_if ctrl ();

    core_decoder u_decoder (
        .instr_i (imem_rdata_i),
        .ctrl    (ctrl)
    );

    core_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (ctrl.rs1_addr),
        .rs2_addr_i (ctrl.rs2_addr),
        .rd_addr_i  (ctrl.rd_addr),
        .rd_wen_i   (ctrl.rf_wen && retire),
        .rd_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .gp_o       (gp_o)
    );

    core_alu u_alu (
        .ctrl       (ctrl),
        .op1_i      (op1),
        .op2_i      (op2),
        .result_o   (alu_result),
        .br_taken_o (br_taken)
    );

    // loads finish one state later than everything else
    assign retire = (state_q == st_exec && !ctrl.is_load) || state_q == st_load;

    always_comb begin
        case (ctrl.op1_sel)
            op1_pc:   op1 = pc_q;
            op1_zero: op1 = '0;
            default:  op1 = rs1_data;
        endcase
        op2 = (ctrl.op2_sel == op2_imm) ? ctrl.imm : rs2_data;
    end

    assign pc_plus4 = pc_q + 32'd4;

    always_comb begin
        if (br_taken)
            pc_next = pc_q + ctrl.br_imm;
        else if (ctrl.jump)
            pc_next = {alu_result[xlen-1:1], 1'b0}; // bit 0 only matters for jalr
        else
            pc_next = pc_plus4;
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:  wb_data = dmem_rdata_i;
            wb_pc4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_fetch;
            pc_q    <= reset_pc;
        end else begin
            case (state_q)
                st_fetch: if (!exit_o) state_q <= st_exec; // parked once exit is hit
                st_exec:  state_q <= ctrl.is_load ? st_load : st_fetch;
                default:  state_q <= st_fetch;
            endcase
            if (retire) begin
                pc_q <= pc_next;
            end
        end
    end

    assign imem_addr_o  = pc_q;
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_wen_o   = ctrl.mem_wen && state_q == st_exec;
    assign exit_o       = pc_q == exit_addr;

endmodule

`default_nettype wire

/* verif/core_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module core_assertions (
    input logic            clk,
    input logic            rst_n,
    input core_pkg::word_t imem_addr_i,
    input logic            dmem_wen_i,
    input logic            exit_i
);
    int assert_errors = 0; // failed properties so far

    single_store: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_wen_i |=> !dmem_wen_i)
        else begin
            assert_errors++;
            $error("dmem_wen_o high on two cycles in a row");
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr_i[1:0] == 2'b00)
        else begin
            assert_errors++;
            $error("imem_addr_o not word aligned");
        end

    exit_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        exit_i |=> exit_i)
        else begin
            assert_errors++;
            $error("exit_o dropped after rising");
        end

    // parked core must stay quiet
    no_store_at_exit: assert property (@(posedge clk) disable iff (!rst_n)
        exit_i |-> !dmem_wen_i)
        else begin
            assert_errors++;
            $error("dmem_wen_o high while exit_o is high");
        end

endmodule

`default_nettype wire

/* verif/core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam int    reset_cycles = 16;
    localparam int    exit_word    = int'(exit_addr >> 2);
    localparam int    max_cycles   = 3 * exit_word + reset_cycles + 200;
    localparam int    main_words   = 160; // random part of the program
    localparam int    dump_word    = 32'h780 >> 2; // x1..x31 land here
    localparam word_t nop          = 32'h0000_0013;

    logic       clk;
    logic       rst_n;
    word_t      imem_addr;
    word_t      imem_rdata;
    word_t      dmem_addr;
    word_t      dmem_wdata;
    logic       dmem_wen;
    word_t      dmem_rdata;
    logic       exit_flag;
    word_t      gp;
    logic [9:0] i_idx;
    logic [9:0] d_idx;

    word_t imem [1024];
    word_t dmem [1024];
    word_t m_dmem [1024]; // reference model state
    word_t m_regs [32];
    word_t exp_addr_q [$];
    word_t exp_data_q [$];
    word_t act_addr_q [$];
    word_t act_data_q [$];
    int    m_instrs;
    int    m_loads;
    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    cycles;

    core core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_wen_o   (dmem_wen),
        .dmem_rdata_i (dmem_rdata),
        .exit_o       (exit_flag),
        .gp_o         (gp)
    );

    bind core core_assertions core_assertions_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr_i (imem_addr_o),
        .dmem_wen_i  (dmem_wen_o),
        .exit_i      (exit_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // both memories answer one cycle later
    always @(posedge clk) begin
        i_idx = imem_addr[11:2];
        d_idx = dmem_addr[11:2];
        if (dmem_wen) begin
            dmem[d_idx] = dmem_wdata;
            act_addr_q.push_back(dmem_addr);
            act_data_q.push_back(dmem_wdata);
        end
        #1;
        imem_rdata = imem[i_idx];
        dmem_rdata = dmem[d_idx];
    end

    function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t b_type(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic word_t j_type(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic gen_program();
        word_t      r;
        word_t      v;
        logic [4:0] rd;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        int         tgt;
        for (int i = 0; i < 1024; i++) begin
            imem[10'(i)] = (i < exit_word) ? nop : {i[15:0], 16'hdead};
            dmem[10'(i)] = {i[15:0], ~i[15:0]} ^ 32'h5a5a_0f0f;
        end
        for (int i = 0; i < main_words; i++) begin
            r   = $urandom;
            v   = $urandom;
            rd  = r[11:7];
            f3  = r[14:12];
            tgt = i + 2 + int'(v[2:0]); // forward only
            if (tgt > main_words)
                tgt = main_words;
            case (r[31:28])
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    f7 = (r[25] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
                    imem[10'(i)] = r_type(f7, r[24:20], r[19:15], f3, rd, 7'h33);
                end
                4'd4, 4'd5, 4'd6: begin
                    if (f3 == 3'b001)
                        imm = {7'h00, v[4:0]};
                    else if (f3 == 3'b101)
                        imm = {1'b0, r[25], 5'b0, v[4:0]};
                    else
                        imm = v[11:0];
                    imem[10'(i)] = i_type(imm, r[19:15], f3, rd, 7'h13);
                end
                4'd7:  imem[10'(i)] = {v[31:12], rd, 7'h37}; // lui
                4'd8:  imem[10'(i)] = {v[31:12], rd, 7'h17}; // auipc
                4'd9, 4'd10: begin
                    if (f3 == 3'b010 || f3 == 3'b011)
                        f3 = f3 + 3'd2;
                    imem[10'(i)] = b_type(13'((tgt - i) * 4), r[24:20], r[19:15], f3);
                end
                4'd11: imem[10'(i)] = j_type(21'((tgt - i) * 4), rd);
                4'd12, 4'd13: begin // lw from a small shared pool
                    imem[10'(i)] = i_type({6'b0, v[3:0], 2'b0}, 5'd0, 3'b010, rd, 7'h03);
                end
                default: imem[10'(i)] = s_type({6'b0, v[3:0], 2'b0}, r[24:20], 5'd0);
            endcase
        end
        imem[10'(main_words)]     = {20'h0, 5'd5, 7'h17};
        imem[10'(main_words + 1)] = i_type(12'd16, 5'd5, 3'b000, 5'd1, 7'h67);
        imem[10'(main_words + 2)] = i_type(12'h7ff, 5'd0, 3'b000, 5'd7, 7'h13);
        imem[10'(main_words + 3)] = i_type(12'h7ff, 5'd0, 3'b000, 5'd7, 7'h13);
        imem[10'(main_words + 4)] = i_type(12'd21, 5'd5, 3'b000, 5'd8, 7'h13);
        imem[10'(main_words + 5)] = i_type(12'd12, 5'd8, 3'b000, 5'd9, 7'h67); // odd target
        imem[10'(main_words + 6)] = i_type(12'hfff, 5'd0, 3'b000, 5'd10, 7'h13);
        imem[10'(main_words + 7)] = i_type(12'hfff, 5'd0, 3'b000, 5'd10, 7'h13);
        for (int x = 1; x < 32; x++) begin
            imem[10'(main_words + 7 + x)] = s_type(12'((dump_word + x) * 4), 5'(x), 5'd0);
        end
    endtask

    // instruction level model, runs the whole program up front
    task automatic run_model();
        word_t      pc;
        word_t      w;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      nxt;
        word_t      addr;
        word_t      ii;
        word_t      is;
        word_t      ib;
        word_t      ij;
        word_t      iu;
        logic [2:0] f3;
        logic       wr;
        pc       = reset_pc;
        m_instrs = 0;
        m_loads  = 0;
        for (int i = 0; i < 32; i++)
            m_regs[5'(i)] = '0;
        for (int i = 0; i < 1024; i++)
            m_dmem[10'(i)] = dmem[10'(i)];
        while (pc != exit_addr && m_instrs < 4 * exit_word) begin
            w   = imem[pc[11:2]];
            f3  = w[14:12];
            a   = m_regs[w[19:15]];
            b   = m_regs[w[24:20]];
            ii  = {{20{w[31]}}, w[31:20]};
            is  = {{20{w[31]}}, w[31:25], w[11:7]};
            ib  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            ij  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            iu  = {w[31:12], 12'b0};
            res = '0;
            wr  = 1'b1;
            nxt = pc + 32'd4;
            case (w[6:0])
                7'h33: res = alu_ref(f3, w[30], a, b);
                7'h13: res = alu_ref(f3, w[30] && f3 == 3'b101, a, ii);
                7'h37: res = iu;
                7'h17: res = pc + iu;
                7'h6f: begin
                    res = pc + 32'd4;
                    nxt = pc + ij;
                end
                7'h67: begin
                    res = pc + 32'd4;
                    nxt = (a + ii) & ~32'd1;
                end
                7'h03: begin
                    addr = a + ii;
                    res  = m_dmem[addr[11:2]];
                    m_loads++;
                end
                7'h23: begin
                    wr   = 1'b0;
                    addr = a + is;
                    m_dmem[addr[11:2]] = b;
                    exp_addr_q.push_back(addr);
                    exp_data_q.push_back(b);
                end
                7'h63: begin
                    wr = 1'b0;
                    if (branch_ref(f3, a, b))
                        nxt = pc + ib;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0)
                m_regs[w[11:7]] = res;
            pc = nxt;
            m_instrs++;
        end
    endtask

    task automatic compare(string name, word_t expected, word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end
    endtask

    initial begin
        int e0;
        int n;
        int stores_at_exit;
        int assert_fails;
        rst_n        = 1'b0;
        imem_rdata   = '0;
        dmem_rdata   = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        void'($urandom(32'he0cc));
        gen_program();
        run_model();

        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;

        @(negedge clk);
        e0 = errors;
        compare("reset imem_addr", reset_pc, imem_addr);
        compare("reset exit", '0, {31'b0, exit_flag});
        compare("reset dmem_wen", '0, {31'b0, dmem_wen});
        finish_test("reset", e0);

        while (!exit_flag && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end

        if (!exit_flag) begin
            $display("ERROR: core never reached exit within %0d cycles", cycles);
            $display("Simulation finished: FAIL");
        end else begin
            stores_at_exit = act_addr_q.size();
            repeat (20) @(negedge clk); // watch the parked core

            e0 = errors;
            compare("store_trace count", exp_addr_q.size(), act_addr_q.size());
            n = (exp_addr_q.size() < act_addr_q.size()) ? exp_addr_q.size() : act_addr_q.size();
            for (int i = 0; i < n; i++) begin
                compare($sformatf("store_trace addr %0d", i), exp_addr_q[i], act_addr_q[i]);
                compare($sformatf("store_trace data %0d", i), exp_data_q[i], act_data_q[i]);
            end
            finish_test("store_trace", e0);

            e0 = errors;
            for (int i = 0; i < 1024; i++) begin
                compare($sformatf("dmem_image word %0d", i), m_dmem[10'(i)], dmem[10'(i)]);
            end
            finish_test("dmem_image", e0);

            e0 = errors;
            for (int x = 1; x < 32; x++) begin
                compare($sformatf("reg_dump x%0d", x), m_regs[5'(x)],
                        dmem[10'(dump_word + x)]);
            end
            finish_test("reg_dump", e0);

            e0 = errors;
            compare("exit_timing cycles", 2 * m_instrs + m_loads, cycles);
            compare("exit_timing gp", m_regs[gp_reg], gp);
            compare("exit_timing late stores", stores_at_exit, act_addr_q.size());
            compare("exit_timing exit held", 32'd1, {31'b0, exit_flag});
            finish_test("exit_timing", e0);

            assert_fails = core_i.core_assertions_i.assert_errors;
            $display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
                     tests_run, tests_failed, checks, errors, assert_fails);
            if (errors == 0 && assert_fails == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* core.f */
source/core_pkg.sv
source/core_ctrl_if.sv
source/core_decoder.sv
source/core_regfile.sv
source/core_alu.sv
source/core.sv
verif/core_assertions.sv
verif/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
